/* src/core_pkg.sv */
`default_nettype none

package core_pkg;

    // Data and address width
    localparam int XLEN = 32;

    // Register index width, 32 architectural registers
    localparam int REG_ADDR_W = 5;

    // Major opcodes the core executes
    typedef enum logic [6:0] {
        OP_IMM = 7'b0010011,
        OP     = 7'b0110011,
        LUI    = 7'b0110111
    } rv_opcode_t;

    // ALU operations, selected in decode
    typedef enum logic [3:0] {
        ALU_ADD    = 4'd0,
        ALU_SUB    = 4'd1,
        ALU_SLL    = 4'd2,
        ALU_SLT    = 4'd3,
        ALU_SLTU   = 4'd4,
        ALU_XOR    = 4'd5,
        ALU_SRL    = 4'd6,
        ALU_SRA    = 4'd7,
        ALU_OR     = 4'd8,
        ALU_AND    = 4'd9,
        // Operand b straight through, used by LUI
        ALU_PASS_B = 4'd10
    } alu_op_t;

    // Fetch to decode
    typedef struct packed {
        logic [XLEN-1:0] pc;
        logic [XLEN-1:0] instruction;
    } fetch_packet_t;

    // Decode to ALU, operands already resolved
    typedef struct packed {
        logic [XLEN-1:0]       pc;
        logic [REG_ADDR_W-1:0] rd;
        alu_op_t               alu_op;
        logic [XLEN-1:0]       operand_a;
        logic [XLEN-1:0]       operand_b;
        logic                  illegal;
    } issue_packet_t;

    // ALU to write-back and the retire port
    typedef struct packed {
        logic [XLEN-1:0]       pc;
        logic [REG_ADDR_W-1:0] rd;
        logic [XLEN-1:0]       result;
        logic                  illegal;
    } retire_packet_t;

endpackage

`default_nettype wire

/* src/fetch.sv */
`timescale 1ns/1ps
`default_nettype none

module fetch #(
    parameter logic [core_pkg::XLEN-1:0] RESET_PC = '0
) (
    input  wire logic                      clk,
    input  wire logic                      rst_n,
    output logic                           imem_en,
    output logic [core_pkg::XLEN-1:0]      imem_addr,
    input  wire logic [core_pkg::XLEN-1:0] imem_data,
    output logic                           fetch_valid,
    output core_pkg::fetch_packet_t        fetch_packet,
    input  wire logic                      fetch_ready
);

    logic [core_pkg::XLEN-1:0] pc;
    logic [core_pkg::XLEN-1:0] pending_pc;
    logic                      request_pending;
    logic                      started;
    core_pkg::fetch_packet_t   buffer [2];
    logic                      write_ptr;
    logic                      read_ptr;
    logic [1:0]                buffer_count;
    logic                      buffer_push;
    logic                      buffer_pop;
    logic [1:0]                occupancy;

    // Word from last cycle's request is on imem_data now
    assign buffer_push = request_pending;
    assign buffer_pop  = fetch_valid && fetch_ready;

    // Entries held after this edge, counting the word in flight
    assign occupancy = buffer_count + {1'b0, request_pending} - {1'b0, buffer_pop};

    // Request only if the returning word is sure to find a slot
    assign imem_en   = started && (occupancy < 2'd2);
    assign imem_addr = pc;

    assign fetch_valid  = (buffer_count != 2'd0);
    assign fetch_packet = buffer[read_ptr];

    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            pc              <= RESET_PC;
            request_pending <= 1'b0;
            started         <= 1'b0;
            write_ptr       <= 1'b0;
            read_ptr        <= 1'b0;
            buffer_count    <= 2'd0;
        end else begin
            // First request goes out the cycle after reset
            started         <= 1'b1;
            request_pending <= imem_en;
            if (imem_en)
                pc <= pc + core_pkg::XLEN'(4);
            if (buffer_push)
                write_ptr <= ~write_ptr;
            if (buffer_pop)
                read_ptr <= ~read_ptr;
            buffer_count <= buffer_count + {1'b0, buffer_push} - {1'b0, buffer_pop};
        end
    end

    // PC of the outstanding request, paired with its word on return
    always_ff @(posedge clk) begin
        if (imem_en)
            pending_pc <= pc;
        if (buffer_push)
            buffer[write_ptr] <= '{pc: pending_pc, instruction: imem_data};
    end

    // Request gating one cycle earlier must leave a free entry
    buffer_no_overflow: assert property (
        @(posedge clk) disable iff (!rst_n)
        buffer_push |-> (buffer_count != 2'd2)
    ) else $error("fetch buffer written while full");

endmodule

`default_nettype wire

/* src/decode.sv */
`timescale 1ns/1ps
`default_nettype none

module decode (
    input  wire logic                                 clk,
    input  wire logic                                 rst_n,
    input  wire logic                                 fetch_valid,
    input  wire core_pkg::fetch_packet_t              fetch_packet,
    output logic                                      fetch_ready,
    output logic [core_pkg::REG_ADDR_W-1:0]           rs1_addr,
    output logic [core_pkg::REG_ADDR_W-1:0]           rs2_addr,
    input  wire logic [core_pkg::XLEN-1:0]            rs1_data,
    input  wire logic [core_pkg::XLEN-1:0]            rs2_data,
    output logic                                      issue_valid,
    output core_pkg::issue_packet_t                   issue_packet,
    input  wire logic                                 issue_ready,
    input  wire logic                                 clear_valid,
    input  wire logic [core_pkg::REG_ADDR_W-1:0]      clear_rd
);

    logic [core_pkg::XLEN-1:0] instruction;
    core_pkg::rv_opcode_t      opcode;
    logic [2:0]                funct3;
    logic [6:0]                funct7;
    logic [core_pkg::XLEN-1:0] imm_i;
    logic [core_pkg::XLEN-1:0] imm_u;
    logic                      legal;
    logic                      rs1_used;
    logic                      rs2_used;
    logic                      hazard;
    logic                      issue_fire;
    logic [31:0]               in_use;
    core_pkg::alu_op_t         alu_op;

    assign instruction = fetch_packet.instruction;
    assign opcode      = core_pkg::rv_opcode_t'(instruction[6:0]);
    assign funct3      = instruction[14:12];
    assign funct7      = instruction[31:25];
    assign rs1_addr    = instruction[19:15];
    assign rs2_addr    = instruction[24:20];

    // Sign extended I-type and upper U-type immediates
    assign imm_i = {{20{instruction[31]}}, instruction[31:20]};
    assign imm_u = {instruction[31:12], 12'b0};

    always_comb begin
        legal    = 1'b0;
        rs1_used = 1'b0;
        rs2_used = 1'b0;
        case (opcode)
            core_pkg::OP: begin
                // Only SUB and SRA carry funct7 bit 5
                legal = (funct7 == 7'b0000000) ||
                        ((funct7 == 7'b0100000) && (funct3 == 3'b000 || funct3 == 3'b101));
                rs1_used = legal;
                rs2_used = legal;
            end
            core_pkg::OP_IMM: begin
                if (funct3 == 3'b001)
                    legal = (funct7 == 7'b0000000);
                else if (funct3 == 3'b101)
                    legal = (funct7 == 7'b0000000) || (funct7 == 7'b0100000);
                else
                    legal = 1'b1;
                rs1_used = legal;
            end
            core_pkg::LUI: legal = 1'b1;
            default:       legal = 1'b0;
        endcase
    end

    // funct3 picks the operation and funct7 bit 5 picks SUB or SRA
    always_comb begin
        case (funct3)
            3'b000:  alu_op = (opcode == core_pkg::OP && funct7[5]) ? core_pkg::ALU_SUB
                                                                    : core_pkg::ALU_ADD;
            3'b001:  alu_op = core_pkg::ALU_SLL;
            3'b010:  alu_op = core_pkg::ALU_SLT;
            3'b011:  alu_op = core_pkg::ALU_SLTU;
            3'b100:  alu_op = core_pkg::ALU_XOR;
            3'b101:  alu_op = funct7[5] ? core_pkg::ALU_SRA : core_pkg::ALU_SRL;
            3'b110:  alu_op = core_pkg::ALU_OR;
            default: alu_op = core_pkg::ALU_AND;
        endcase
    end

    always_comb begin
        issue_packet.pc        = fetch_packet.pc;
        issue_packet.illegal   = !legal;
        // Illegal entries carry rd 0 so nothing is written or tracked
        issue_packet.rd        = legal ? instruction[11:7] : '0;
        issue_packet.alu_op    = (opcode == core_pkg::LUI) ? core_pkg::ALU_PASS_B : alu_op;
        issue_packet.operand_a = rs1_used ? rs1_data : '0;
        if (opcode == core_pkg::LUI)
            issue_packet.operand_b = imm_u;
        else if (rs2_used)
            issue_packet.operand_b = rs2_data;
        else if (legal)
            issue_packet.operand_b = imm_i;
        else
            issue_packet.operand_b = '0;
    end

    // Stall on pending sources and on a pending destination
    assign hazard = (rs1_used && in_use[rs1_addr]) ||
                    (rs2_used && in_use[rs2_addr]) ||
                    in_use[issue_packet.rd];

    assign issue_valid = fetch_valid && !hazard;
    assign issue_fire  = issue_valid && issue_ready;
    assign fetch_ready = issue_fire;

    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            in_use <= '0;
        end else begin
            if (clear_valid)
                in_use[clear_rd] <= 1'b0;
            // x0 is never tracked
            if (issue_fire && issue_packet.rd != '0)
                in_use[issue_packet.rd] <= 1'b1;
        end
    end

    // Write-back only clears what an earlier issue marked
    clear_only_in_use: assert property (
        @(posedge clk) disable iff (!rst_n)
        clear_valid |-> in_use[clear_rd]
    ) else $error("in-use clear for a register not in use");

endmodule

`default_nettype wire

/* src/register_file.sv */
`timescale 1ns/1ps
`default_nettype none

module register_file (
    input  wire logic                            clk,
    input  wire logic                            rst_n,
    input  wire logic [core_pkg::REG_ADDR_W-1:0] rs1_addr,
    input  wire logic [core_pkg::REG_ADDR_W-1:0] rs2_addr,
    output logic [core_pkg::XLEN-1:0]            rs1_data,
    output logic [core_pkg::XLEN-1:0]            rs2_data,
    input  wire logic                            rf_we,
    input  wire logic [core_pkg::REG_ADDR_W-1:0] rf_waddr,
    input  wire logic [core_pkg::XLEN-1:0]       rf_wdata
);

    // x1 to x31, x0 has no storage
    logic [core_pkg::XLEN-1:0] registers [1:31];

    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            // Architectural state starts at zero
            for (int i = 1; i < 32; i++)
                registers[i] <= '0;
        end else if (rf_we && rf_waddr != '0) begin
            registers[rf_waddr] <= rf_wdata;
        end
    end

    // Combinational reads, x0 hardwired
    always_comb begin
        if (rs1_addr == '0)
            rs1_data = '0;
        else
            rs1_data = registers[rs1_addr];
        if (rs2_addr == '0)
            rs2_data = '0;
        else
            rs2_data = registers[rs2_addr];
    end

endmodule

`default_nettype wire

/* src/alu_unit.sv */
`timescale 1ns/1ps
`default_nettype none

module alu_unit (
    input  wire logic                    clk,
    input  wire logic                    rst_n,
    input  wire logic                    issue_valid,
    input  wire core_pkg::issue_packet_t issue_packet,
    output logic                         issue_ready,
    output logic                         alu_valid,
    output core_pkg::retire_packet_t     alu_packet,
    input  wire logic                    alu_ready
);

    logic [core_pkg::XLEN-1:0] operand_a;
    logic [core_pkg::XLEN-1:0] operand_b;
    logic [core_pkg::XLEN-1:0] result;
    logic [4:0]                shamt;
    logic                      issue_fire;

    assign operand_a = issue_packet.operand_a;
    assign operand_b = issue_packet.operand_b;
    // Shift amount from the low bits only
    assign shamt     = operand_b[4:0];

    always_comb begin
        case (issue_packet.alu_op)
            core_pkg::ALU_ADD:    result = operand_a + operand_b;
            core_pkg::ALU_SUB:    result = operand_a - operand_b;
            core_pkg::ALU_SLL:    result = operand_a << shamt;
            core_pkg::ALU_SLT:
                result = {31'b0, $signed(operand_a) < $signed(operand_b)};
            core_pkg::ALU_SLTU:   result = {31'b0, operand_a < operand_b};
            core_pkg::ALU_XOR:    result = operand_a ^ operand_b;
            core_pkg::ALU_SRL:    result = operand_a >> shamt;
            core_pkg::ALU_SRA:    result = $unsigned($signed(operand_a) >>> shamt);
            core_pkg::ALU_OR:     result = operand_a | operand_b;
            core_pkg::ALU_AND:    result = operand_a & operand_b;
            core_pkg::ALU_PASS_B: result = operand_b;
            default:              result = '0;
        endcase
    end

    // Accept when empty or when the held result drains this cycle
    assign issue_ready = !alu_valid || alu_ready;
    assign issue_fire  = issue_valid && issue_ready;

    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n)
            alu_valid <= 1'b0;
        else if (issue_ready)
            alu_valid <= issue_valid;
    end

    // Held while write-back stalls
    always_ff @(posedge clk) begin
        if (issue_fire) begin
            alu_packet <= '{
                pc:      issue_packet.pc,
                rd:      issue_packet.rd,
                result:  issue_packet.illegal ? '0 : result,
                illegal: issue_packet.illegal
            };
        end
    end

endmodule

`default_nettype wire

/* src/write_back.sv */
`timescale 1ns/1ps
`default_nettype none

module write_back (
    input  wire logic                             clk,
    input  wire logic                             rst_n,
    input  wire logic                             alu_valid,
    input  wire core_pkg::retire_packet_t         alu_packet,
    output logic                                  alu_ready,
    output logic                                  retire_valid,
    output core_pkg::retire_packet_t              retire,
    input  wire logic                             retire_ready,
    output logic                                  rf_we,
    output logic [core_pkg::REG_ADDR_W-1:0]       rf_waddr,
    output logic [core_pkg::XLEN-1:0]             rf_wdata,
    output logic                                  clear_valid,
    output logic [core_pkg::REG_ADDR_W-1:0]       clear_rd
);

    logic retire_fire;

    assign alu_ready   = !retire_valid || retire_ready;
    assign retire_fire = retire_valid && retire_ready;

    // Register write and in-use clear land on the retire edge
    assign rf_we       = retire_fire && !retire.illegal && (retire.rd != '0);
    assign rf_waddr    = retire.rd;
    assign rf_wdata    = retire.result;
    assign clear_valid = rf_we;
    assign clear_rd    = retire.rd;

    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n)
            retire_valid <= 1'b0;
        else if (alu_ready)
            retire_valid <= alu_valid;
    end

    always_ff @(posedge clk) begin
        if (alu_valid && alu_ready)
            retire <= alu_packet;
    end

    retire_stable_under_stall: assert property (
        @(posedge clk) disable iff (!rst_n)
        retire_valid && !retire_ready |=> retire_valid && $stable(retire)
    ) else $error("retire packet changed while stalled");

endmodule

`default_nettype wire

/* src/core_top.sv */
`timescale 1ns/1ps
`default_nettype none

module core_top #(
    parameter logic [core_pkg::XLEN-1:0] RESET_PC = '0
) (
    input  wire logic                      clk,
    input  wire logic                      rst_n,
    output logic                           imem_en,
    output logic [core_pkg::XLEN-1:0]      imem_addr,
    input  wire logic [core_pkg::XLEN-1:0] imem_data,
    output logic                           retire_valid,
    output core_pkg::retire_packet_t       retire,
    input  wire logic                      retire_ready
);

    // Fetch buffer to decode
    logic                    fetch_valid;
    logic                    fetch_ready;
    core_pkg::fetch_packet_t fetch_packet;

    // Register file read ports
    logic [core_pkg::REG_ADDR_W-1:0] rs1_addr;
    logic [core_pkg::REG_ADDR_W-1:0] rs2_addr;
    logic [core_pkg::XLEN-1:0]       rs1_data;
    logic [core_pkg::XLEN-1:0]       rs2_data;

    // Issue into the ALU
    logic                    issue_valid;
    logic                    issue_ready;
    core_pkg::issue_packet_t issue_packet;

    // ALU result into write-back
    logic                     alu_valid;
    logic                     alu_ready;
    core_pkg::retire_packet_t alu_packet;

    // Write-back to register file and scoreboard
    logic                            rf_we;
    logic [core_pkg::REG_ADDR_W-1:0] rf_waddr;
    logic [core_pkg::XLEN-1:0]       rf_wdata;
    logic                            clear_valid;
    logic [core_pkg::REG_ADDR_W-1:0] clear_rd;

    // Front end
    fetch #(.RESET_PC(RESET_PC)) fetch_block (.*);

    // Decode/issue
    decode decode_block (.*);
    register_file register_file_block (.*);

    // Execute
    alu_unit alu_unit_block (.*);

    // Retire
    write_back write_back_block (.*);

endmodule

`default_nettype wire

/* verif/core_tb.sv */
`timescale 1ns/1ps
`default_nettype none

module core_tb;

    localparam logic [core_pkg::XLEN-1:0] RESET_PC = 32'h0000_0100;
    // ADDI x0,x0,0
    localparam logic [31:0] NOP_WORD = 32'h0000_0013;
    localparam int PROGRAM_DEPTH = 256;

    // DUT inputs, all set at time zero
    logic                     clk = 1'b0;
    logic                     rst_n = 1'b0;
    logic [31:0]              imem_data = NOP_WORD;
    logic                     retire_ready = 1'b0;
    logic                     imem_en;
    logic [31:0]              imem_addr;
    logic                     retire_valid;
    core_pkg::retire_packet_t retire;

    // Program image and reference state
    logic [31:0] program_mem [PROGRAM_DEPTH];
    int          program_len = 0;
    logic [31:0] reference_regs [32];

    // Run bookkeeping
    string current_test = "";
    int    retired_count = 0;
    int    test_errors = 0;
    int    error_count = 0;
    int    check_count = 0;
    int    test_count = 0;
    int    reset_edges = 0;
    int    cycle_count = 0;
    int    cycle_limit = 100;
    logic  checking = 1'b0;
    logic  apply_backpressure = 1'b0;
    logic  first_request_seen = 1'b0;
    logic  timed_out = 1'b0;

    core_top #(
        .RESET_PC(RESET_PC)
    ) uut (
        .clk(clk),
        .rst_n(rst_n),
        .imem_en(imem_en),
        .imem_addr(imem_addr),
        .imem_data(imem_data),
        .retire_valid(retire_valid),
        .retire(retire),
        .retire_ready(retire_ready)
    );

    initial begin
        forever #20 clk = ~clk;
    end

    // Instruction encoders
    function automatic logic [31:0] r_type_word(input logic [6:0] funct7, input logic [4:0] rs2,
                                                input logic [4:0] rs1, input logic [2:0] funct3,
                                                input logic [4:0] rd);
        return {funct7, rs2, rs1, funct3, rd, core_pkg::OP};
    endfunction

    function automatic logic [31:0] i_type_word(input logic [11:0] imm, input logic [4:0] rs1,
                                                input logic [2:0] funct3, input logic [4:0] rd);
        return {imm, rs1, funct3, rd, core_pkg::OP_IMM};
    endfunction

    function automatic logic [31:0] u_type_word(input logic [19:0] imm, input logic [4:0] rd);
        return {imm, rd, core_pkg::LUI};
    endfunction

    // Everything outside the program reads as a NOP
    function automatic logic [31:0] instruction_at(input logic [31:0] addr);
        logic [31:0] index;
        index = (addr - RESET_PC) >> 2;
        if (addr < RESET_PC || index >= 32'(program_len))
            return NOP_WORD;
        return program_mem[8'(index)];
    endfunction

    // RV32I arithmetic by funct3, alt selects SUB and SRA
    function automatic logic [31:0] isa_result(input logic [2:0] funct3, input logic alt,
                                               input logic [31:0] a, input logic [31:0] b);
        logic [31:0] value;
        case (funct3)
            3'd0:    value = alt ? a - b : a + b;
            3'd1:    value = a << b[4:0];
            3'd2:    value = ($signed(a) < $signed(b)) ? 32'd1 : 32'd0;
            3'd3:    value = (a < b) ? 32'd1 : 32'd0;
            3'd4:    value = a ^ b;
            3'd5: begin
                if (alt)
                    value = $unsigned($signed(a) >>> b[4:0]);
                else
                    value = a >> b[4:0];
            end
            3'd6:    value = a | b;
            default: value = a & b;
        endcase
        return value;
    endfunction

    // Executes one instruction on the reference registers
    function automatic core_pkg::retire_packet_t reference_step(input logic [31:0] pc,
                                                                input logic [31:0] word);
        core_pkg::retire_packet_t expected;
        logic [2:0]  funct3;
        logic [6:0]  funct7;
        logic [31:0] a;
        logic [31:0] b;
        logic        legal;
        logic        alt;
        funct3 = word[14:12];
        funct7 = word[31:25];
        a      = reference_regs[word[19:15]];
        b      = {{20{word[31]}}, word[31:20]};
        legal  = 1'b0;
        alt    = 1'b0;
        case (word[6:0])
            core_pkg::OP: begin
                b     = reference_regs[word[24:20]];
                alt   = funct7[5];
                legal = (funct7 == 7'h00) ||
                        (funct7 == 7'h20 && (funct3 == 3'd0 || funct3 == 3'd5));
            end
            core_pkg::OP_IMM: begin
                // ADDI has no SUB form, only the right shift reads bit 30
                alt = (funct3 == 3'd5) && funct7[5];
                if (funct3 == 3'd1)
                    legal = (funct7 == 7'h00);
                else if (funct3 == 3'd5)
                    legal = (funct7 == 7'h00) || (funct7 == 7'h20);
                else
                    legal = 1'b1;
            end
            core_pkg::LUI: legal = 1'b1;
            default:       legal = 1'b0;
        endcase
        expected.pc      = pc;
        expected.illegal = !legal;
        if (!legal) begin
            expected.rd     = '0;
            expected.result = '0;
        end else begin
            expected.rd = word[11:7];
            if (word[6:0] == core_pkg::LUI)
                expected.result = {word[31:12], 12'h000};
            else
                expected.result = isa_result(funct3, alt, a, b);
            if (expected.rd != 5'd0)
                reference_regs[expected.rd] = expected.result;
        end
        return expected;
    endfunction

    task automatic check_value(input string field, input logic [31:0] expected,
                               input logic [31:0] actual);
        check_count++;
        if (actual !== expected) begin
            error_count++;
            test_errors++;
            $display("[ERROR] %s %s: expected %h, actual %h", current_test, field, expected,
                     actual);
        end
    endtask

    // Memory answers one cycle after the request
    always @(posedge clk) begin
        if (imem_en)
            imem_data <= instruction_at(imem_addr);
    end

    // Retire port back-pressure
    always @(posedge clk) begin
        if (apply_backpressure)
            retire_ready <= ($urandom % 2) == 0;
        else
            retire_ready <= 1'b1;
    end

    // Compare process, reference steps in program order on each retire handshake
    always @(posedge clk) begin
        core_pkg::retire_packet_t expected;
        if (!rst_n) begin
            retired_count      <= 0;
            first_request_seen <= 1'b0;
            reference_regs = '{default: '0};
            // First reset edge may still see unknown state
            if (reset_edges == 0) begin
                test_errors = 0;
            end else begin
                check_value("retire_valid in reset", 32'd0, 32'(retire_valid));
                check_value("imem_en in reset", 32'd0, 32'(imem_en));
            end
            reset_edges <= reset_edges + 1;
        end else begin
            reset_edges <= 0;
            if (checking && imem_en && !first_request_seen) begin
                check_value("first imem_addr", RESET_PC, imem_addr);
                first_request_seen <= 1'b1;
            end
            // NOPs past the program end are not compared
            if (checking && retire_valid && retire_ready && retired_count < program_len) begin
                expected = reference_step(RESET_PC + 32'(4 * retired_count),
                                          program_mem[8'(retired_count)]);
                check_value("pc", expected.pc, retire.pc);
                check_value("rd", 32'(expected.rd), 32'(retire.rd));
                check_value("result", expected.result, retire.result);
                check_value("illegal", 32'(expected.illegal), 32'(retire.illegal));
                retired_count <= retired_count + 1;
            end
        end
    end

    // Cycle budget per program
    always @(posedge clk) begin
        if (!rst_n) begin
            cycle_count <= 0;
        end else if (checking) begin
            cycle_count <= cycle_count + 1;
            if (cycle_count >= cycle_limit)
                timed_out <= 1'b1;
        end
    end

    initial begin
        wait (timed_out);
        $display("Timeout in test %s: %0d of %0d instructions retired after %0d cycles",
                 current_test, retired_count, program_len, cycle_count);
        $display("Finished with errors");
        $finish;
    end

    task automatic add_word(input logic [31:0] word);
        program_mem[8'(program_len)] = word;
        program_len++;
    endtask

    function automatic logic [31:0] random_instruction(input bit with_illegal);
        int          kind;
        logic [2:0]  funct3;
        logic [6:0]  funct7;
        logic [11:0] imm;
        kind   = int'($urandom % (with_illegal ? 10 : 9));
        funct3 = 3'($urandom);
        imm    = 12'($urandom);
        funct7 = 7'h00;
        if ((funct3 == 3'd0 || funct3 == 3'd5) && ($urandom % 2) == 0)
            funct7 = 7'h20;
        if (kind < 4)
            return r_type_word(funct7, 5'($urandom), 5'($urandom), funct3, 5'($urandom));
        if (kind < 8) begin
            // Keep shift immediates in the legal encodings
            if (funct3 == 3'd1)
                imm[11:5] = 7'h00;
            if (funct3 == 3'd5)
                imm[11:5] = funct7;
            return i_type_word(imm, 5'($urandom), funct3, 5'($urandom));
        end
        if (kind == 8)
            return u_type_word(20'($urandom), 5'($urandom));
        // Raw word, mostly an unsupported opcode
        return $urandom;
    endfunction

    task automatic run_program(input string name, input logic backpressure);
        current_test = name;
        cycle_limit  = 20 * program_len + 100;
        @(posedge clk);
        rst_n <= 1'b0;
        apply_backpressure = backpressure;
        repeat (3) @(posedge clk);
        rst_n <= 1'b1;
        checking = 1'b1;
        while (retired_count < program_len)
            @(posedge clk);
        checking = 1'b0;
        test_count++;
        $display("Test %s done: %0d instructions, %0d errors", name, program_len, test_errors);
    endtask

    initial begin
        logic [4:0] prev;
        logic [4:0] rd;
        void'($urandom(32'hce6f_ea9a));

        // Reset state and first fetch address
        program_len = 0;
        add_word(i_type_word(12'h005, 5'd0, 3'd0, 5'd1));
        add_word(i_type_word(12'h003, 5'd1, 3'd0, 5'd2));
        add_word(u_type_word(20'h80001, 5'd3));
        run_program("reset_state", 1'b0);

        // x1 negative, x2 a mixed pattern, x3 a shift amount
        program_len = 0;
        add_word(i_type_word(12'hb2e, 5'd0, 3'd0, 5'd1));
        add_word(u_type_word(20'h12345, 5'd2));
        add_word(i_type_word(12'h678, 5'd2, 3'd0, 5'd2));
        add_word(i_type_word(12'h007, 5'd0, 3'd0, 5'd3));
        for (int k = 0; k < 8; k++) begin
            add_word(r_type_word(7'h00, (k == 1 || k == 5) ? 5'd3 : 5'd2, 5'd1, 3'(k),
                                 5'(10 + k)));
        end
        add_word(r_type_word(7'h20, 5'd2, 5'd1, 3'd0, 5'd18));
        add_word(r_type_word(7'h20, 5'd3, 5'd1, 3'd5, 5'd19));
        for (int k = 0; k < 8; k++) begin
            add_word(i_type_word((k == 1 || k == 5) ? 12'h009 : 12'h9c3,
                                 k[0] ? 5'd2 : 5'd1, 3'(k), 5'(20 + k)));
        end
        add_word(i_type_word({7'h20, 5'd4}, 5'd1, 3'd5, 5'd28));
        add_word(u_type_word(20'hfedcb, 5'd29));
        run_program("independent_ops", 1'b0);

        // Each instruction reads the previous destination
        program_len = 0;
        add_word(i_type_word(12'h001, 5'd0, 3'd0, 5'd5));
        prev = 5'd5;
        for (int k = 0; k < 18; k++) begin
            rd = 5'(5 + (k % 3));
            case (k % 3)
                0:       add_word(r_type_word(7'h00, prev, prev, 3'd0, rd));
                1:       add_word(i_type_word(12'h7f3, prev, 3'd4, rd));
                default: add_word(r_type_word(7'h20, 5'd5, prev, 3'd0, rd));
            endcase
            prev = rd;
        end
        run_program("dependency_chain", 1'b0);

        program_len = 0;
        for (int k = 0; k < 40; k++)
            add_word(random_instruction(1'b0));
        run_program("back_pressure", 1'b1);

        // x0 writes, then unsupported encodings around live registers
        program_len = 0;
        add_word(i_type_word(12'h037, 5'd0, 3'd0, 5'd0));
        add_word(i_type_word(12'h009, 5'd0, 3'd0, 5'd1));
        add_word(r_type_word(7'h00, 5'd1, 5'd0, 3'd0, 5'd2));
        add_word(u_type_word(20'habcde, 5'd0));
        add_word(i_type_word(12'h000, 5'd0, 3'd0, 5'd3));
        // LW x2,2(x1)
        add_word({12'h002, 5'd1, 3'b010, 5'd2, 7'b0000011});
        // MUL x2,x1,x1
        add_word(r_type_word(7'h01, 5'd1, 5'd1, 3'd0, 5'd2));
        add_word(i_type_word({7'h20, 5'd3}, 5'd1, 3'd1, 5'd2));
        add_word(r_type_word(7'h20, 5'd1, 5'd1, 3'd4, 5'd2));
        add_word(32'hffff_ffff);
        add_word(32'h0000_0000);
        add_word(r_type_word(7'h00, 5'd1, 5'd2, 3'd0, 5'd4));
        add_word(r_type_word(7'h00, 5'd0, 5'd0, 3'd6, 5'd5));
        run_program("x0_and_illegal", 1'b0);

        program_len = 0;
        for (int k = 0; k < 200; k++)
            add_word(random_instruction(1'b1));
        run_program("random_mix", 1'b1);

        $display("Tests run: %0d, checks: %0d, errors: %0d", test_count, check_count,
                 error_count);
        if (error_count == 0) begin
            $display("Finished with no errors");
        end else begin
            $display("Finished with errors");
        end
        $finish;
    end

endmodule

`default_nettype wire

/* sim.f */
src/core_pkg.sv
src/fetch.sv
src/decode.sv
src/register_file.sv
src/alu_unit.sv
src/write_back.sv
src/core_top.sv
verif/core_tb.sv

/* Makefile */
VERILATOR ?= verilator
VFLAGS    ?= --binary --timing --assert -sv
TOP       := core_tb
FILELIST  := sim.f
OBJ_DIR   := obj_dir
LOG       := sim.log
PASS_MSG  := Finished with no errors

SOURCES   := $(wildcard src/*.sv verif/*.sv)
BINARY    := $(OBJ_DIR)/V$(TOP)

.PHONY: all compile run clean

all: run

compile: $(BINARY)

$(BINARY): $(SOURCES) $(FILELIST)
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) --Mdir $(OBJ_DIR) -f $(FILELIST)

run: $(BINARY)
	./$(BINARY) | tee $(LOG)
	@if grep -q "^$(PASS_MSG)$$" $(LOG); then \
		echo "Simulation passed"; \
	else \
		echo "Simulation failed"; \
		exit 1; \
	fi

clean:
	rm -rf $(OBJ_DIR) $(LOG)
